// ==== include/saturn_params.svh ====
// Width macros for instruction nibbles, nibble addresses and working registers.
`ifndef SATURN_PARAMS_SVH
`define SATURN_PARAMS_SVH

// ********************************************************************
// Datapath widths
// ********************************************************************

`define SATURN_NIB_W  4    // One instruction nibble, also the P width.
`define SATURN_ADDR_W 20   // Nibble address space.
`define SATURN_WORD_W 16   // Working registers A to D.

`endif

// ==== hw/saturn_pkg.sv ====
// Shared types: nibble, address and word vectors, ALU register and opcode enums, decoder states.
`default_nettype none

package saturn_pkg;

`include "saturn_params.svh"

    typedef logic [`SATURN_NIB_W-1:0]  nibble_t;   // Nibble or immediate.
    typedef logic [`SATURN_ADDR_W-1:0] addr_t;     // Nibble address.
    typedef logic [`SATURN_WORD_W-1:0] word_t;     // Register value.

    // ********************************************************************
    // ALU descriptor fields
    // ********************************************************************

    // Codes 0..3 line up with the two-bit register fields of Cx, Dx and Ex.
    typedef enum logic [2:0] {
        ALU_REG_A    = 3'd0,
        ALU_REG_B    = 3'd1,
        ALU_REG_C    = 3'd2,
        ALU_REG_D    = 3'd3,
        ALU_REG_P    = 3'd4,
        ALU_REG_IMM  = 3'd5,     // Immediate from the descriptor.
        ALU_REG_NONE = 3'd6      // No register.
    } alu_reg_e;

    typedef enum logic [2:0] {
        ALU_OP_NOP     = 3'd0,   // Illegal instruction, no write.
        ALU_OP_COPY    = 3'd1,
        ALU_OP_ADD     = 3'd2,
        ALU_OP_SUB     = 3'd3,
        ALU_OP_NIBLOAD = 3'd4    // Load one nibble of C.
    } alu_op_e;

    typedef enum logic [1:0] {
        DEC_IDLE    = 2'd0,      // Waiting for a first nibble.
        DEC_OPERAND = 2'd1,      // Waiting for the second nibble.
        DEC_HOLD    = 2'd2       // Descriptor presented to the ALU.
    } dec_state_e;

endpackage

`default_nettype wire

// ==== hw/saturn_ifs.sv ====
// Decoder-to-ALU operation interface and register file access interface.
`timescale 1ns/1ps
`default_nettype none

// ********************************************************************
// Operation descriptor, valid/ready handshake
// ********************************************************************

interface saturn_op_if;
    import saturn_pkg::*;

    logic     op_valid;   // Descriptor present.
    logic     op_ready;   // ALU can take it.
    alu_op_e  op_code;    // Operation.
    alu_reg_e op_dest;    // Destination register.
    alu_reg_e op_src;     // Source register or IMM.
    nibble_t  op_imm;     // Immediate nibble.
    addr_t    op_pc;      // Address of the first nibble.

    modport source (
        output op_valid, op_code, op_dest, op_src, op_imm, op_pc,
        input  op_ready
    );

    modport sink (
        input  op_valid, op_code, op_dest, op_src, op_imm, op_pc,
        output op_ready
    );
endinterface

// ********************************************************************
// Register file ports, two reads and one write
// ********************************************************************

interface saturn_rf_if;
    import saturn_pkg::*;

    alu_reg_e rd_sel_1;   // Read port 1 select.
    alu_reg_e rd_sel_2;   // Read port 2 select.
    word_t    rd_data_1;  // Read port 1 data.
    word_t    rd_data_2;  // Read port 2 data.
    nibble_t  rd_p;       // Current P.
    logic     wr_en;      // Write strobe.
    alu_reg_e wr_sel;     // Write select.
    word_t    wr_data;    // Write data.

    modport regs (
        input  rd_sel_1, rd_sel_2, wr_en, wr_sel, wr_data,
        output rd_data_1, rd_data_2, rd_p
    );

    modport alu (
        output rd_sel_1, rd_sel_2, wr_en, wr_sel, wr_data,
        input  rd_data_1, rd_data_2, rd_p
    );
endinterface

`default_nettype wire

// ==== hw/saturn_inst_decoder.sv ====
// Nibble-serial instruction decoder FSM that builds ALU operation descriptors.
`timescale 1ns/1ps
`default_nettype none

module saturn_inst_decoder (
    input  wire                  i_clk,
    input  wire                  i_reset,
    input  wire                  i_nib_valid,   // Nibble offered.
    input  wire saturn_pkg::nibble_t i_nibble,  // Instruction nibble.
    input  wire saturn_pkg::addr_t   i_nib_addr, // Its address.
    output logic                 o_nib_ready,   // Decoder can take a nibble.
    saturn_op_if.source          op             // Descriptor to the ALU.
);
    import saturn_pkg::*;

    dec_state_e state;        // FSM state.
    nibble_t    first_nib;    // First nibble, selects the block.
    logic       nib_take;     // Nibble consumed this edge.
    logic       op_take;      // Descriptor consumed this edge.

    assign nib_take = i_nib_valid && o_nib_ready;
    assign op_take  = op.op_valid && op.op_ready;

    // Blocks 2, 3, C, D and E take an operand nibble.
    function automatic logic is_legal(input nibble_t nib);
        case (nib)
            4'h2, 4'h3, 4'hC, 4'hD, 4'hE: is_legal = 1'b1;
            default:                      is_legal = 1'b0;
        endcase
    endfunction

    // Two-bit field to register A..D.
    function automatic alu_reg_e field_reg(input logic [1:0] sel);
        field_reg = alu_reg_e'({1'b0, sel});
    endfunction

    // ********************************************************************
    // Decoder FSM
    // ********************************************************************

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state       <= DEC_IDLE;
            o_nib_ready <= 1'b0;              // Rises on the first cycle after reset.
            op.op_valid <= 1'b0;
        end else begin
            case (state)
                DEC_IDLE: begin
                    o_nib_ready <= 1'b1;
                    if (nib_take) begin
                        op.op_pc  <= i_nib_addr;  // Instruction PC.
                        first_nib <= i_nibble;
                        if (is_legal(i_nibble)) begin
                            state <= DEC_OPERAND;
                        end else begin
                            // Illegal, one nibble long.
                            op.op_code  <= ALU_OP_NOP;
                            op.op_dest  <= ALU_REG_NONE;
                            op.op_src   <= ALU_REG_NONE;
                            op.op_imm   <= '0;
                            op.op_valid <= 1'b1;
                            o_nib_ready <= 1'b0;  // Stall while held.
                            state       <= DEC_HOLD;
                        end
                    end
                end
                DEC_OPERAND: begin
                    if (nib_take) begin
                        op.op_imm   <= i_nibble;  // Only 2n and 3n use it.
                        op.op_valid <= 1'b1;
                        o_nib_ready <= 1'b0;
                        state       <= DEC_HOLD;
                        case (first_nib)
                            4'h2: begin           // P = n.
                                op.op_code <= ALU_OP_COPY;
                                op.op_dest <= ALU_REG_P;
                                op.op_src  <= ALU_REG_IMM;
                            end
                            4'h3: begin           // C[P] = n.
                                op.op_code <= ALU_OP_NIBLOAD;
                                op.op_dest <= ALU_REG_C;
                                op.op_src  <= ALU_REG_IMM;
                            end
                            default: begin        // Cx, Dx, Ex.
                                op.op_dest <= field_reg(i_nibble[3:2]);
                                op.op_src  <= field_reg(i_nibble[1:0]);
                                op.op_code <= (first_nib == 4'hC) ? ALU_OP_ADD :
                                              (first_nib == 4'hD) ? ALU_OP_COPY :
                                                                    ALU_OP_SUB;
                            end
                        endcase
                    end
                end
                DEC_HOLD: begin
                    if (op_take) begin
                        op.op_valid <= 1'b0;
                        o_nib_ready <= 1'b1;      // Back the cycle after transfer.
                        state       <= DEC_IDLE;
                    end
                end
                default: begin
                    state <= DEC_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hw/saturn_reg_file.sv ====
// Working registers A to D and pointer P with two combinational reads and one write.
`timescale 1ns/1ps
`default_nettype none

module saturn_reg_file (
    input  wire        i_clk,
    input  wire        i_reset,
    saturn_rf_if.regs  rf          // Read and write ports.
);
    import saturn_pkg::*;

    word_t   reg_a;   // Working registers.
    word_t   reg_b;
    word_t   reg_c;
    word_t   reg_d;
    nibble_t reg_p;   // Nibble pointer.

    // P reads zero-extended, IMM and NONE read as zero.
    function automatic word_t read_sel(input alu_reg_e sel);
        case (sel)
            ALU_REG_A: read_sel = reg_a;
            ALU_REG_B: read_sel = reg_b;
            ALU_REG_C: read_sel = reg_c;
            ALU_REG_D: read_sel = reg_d;
            ALU_REG_P: read_sel = word_t'(reg_p);
            default:   read_sel = '0;
        endcase
    endfunction

    always_comb begin
        rf.rd_data_1 = read_sel(rf.rd_sel_1);
        rf.rd_data_2 = read_sel(rf.rd_sel_2);
    end

    assign rf.rd_p = reg_p;

    // ********************************************************************
    // Write port
    // ********************************************************************

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            reg_a <= '0;
            reg_b <= '0;
            reg_c <= '0;
            reg_d <= '0;
            reg_p <= '0;
        end else if (rf.wr_en) begin
            case (rf.wr_sel)
                ALU_REG_A: reg_a <= rf.wr_data;
                ALU_REG_B: reg_b <= rf.wr_data;
                ALU_REG_C: reg_c <= rf.wr_data;
                ALU_REG_D: reg_d <= rf.wr_data;
                ALU_REG_P: reg_p <= rf.wr_data[$bits(nibble_t)-1:0];  // Low nibble.
                default: ;                    // IMM and NONE are not stored.
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hw/saturn_alu.sv ====
// ALU that executes descriptors, writes back to the register file and holds one result.
`timescale 1ns/1ps
`default_nettype none

module saturn_alu (
    input  wire                  i_clk,
    input  wire                  i_reset,
    saturn_op_if.sink            op,             // Descriptor from the decoder.
    saturn_rf_if.alu             rf,             // Operand reads and write-back.
    output logic                 o_res_valid,    // Result present.
    input  wire                  i_res_ready,    // Result taken.
    output saturn_pkg::alu_reg_e o_res_reg,      // Register written.
    output saturn_pkg::word_t    o_res_value,    // Value written.
    output saturn_pkg::addr_t    o_res_pc,       // Instruction PC.
    output logic                 o_res_illegal   // Illegal instruction.
);
    import saturn_pkg::*;

    logic  accept;    // Descriptor consumed this edge.
    word_t src_val;   // Source operand.
    word_t result;    // New destination value.

    // Slot empty or draining this edge.
    assign op.op_ready = !o_res_valid || i_res_ready;
    assign accept      = op.op_valid && op.op_ready;

    assign rf.rd_sel_1 = op.op_dest;
    assign rf.rd_sel_2 = op.op_src;

    // ********************************************************************
    // Datapath
    // ********************************************************************

    always_comb begin
        src_val = (op.op_src == ALU_REG_IMM) ? word_t'(op.op_imm) : rf.rd_data_2;
        case (op.op_code)
            ALU_OP_COPY: result = src_val;
            ALU_OP_ADD:  result = rf.rd_data_1 + src_val;   // Wraps.
            ALU_OP_SUB:  result = rf.rd_data_1 - src_val;   // Wraps.
            ALU_OP_NIBLOAD: begin
                result = rf.rd_data_1;                      // Keep other nibbles.
                result[{rf.rd_p[1:0], 2'b00} +: $bits(nibble_t)] = op.op_imm;
            end
            default:     result = '0;                       // NOP.
        endcase
    end

    // Write on the accepting edge so the next descriptor sees it.
    assign rf.wr_en   = accept && (op.op_code != ALU_OP_NOP);
    assign rf.wr_sel  = op.op_dest;
    assign rf.wr_data = result;

    // ********************************************************************
    // Result slot
    // ********************************************************************

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_res_valid <= 1'b0;
        end else if (accept) begin
            o_res_valid <= 1'b1;              // Refill, possibly while draining.
        end else if (i_res_ready) begin
            o_res_valid <= 1'b0;              // Drained.
        end
    end

    always_ff @(posedge i_clk) begin
        if (accept) begin
            o_res_reg     <= op.op_dest;
            o_res_value   <= result;
            o_res_pc      <= op.op_pc;
            o_res_illegal <= (op.op_code == ALU_OP_NOP);
        end
    end

endmodule

`default_nettype wire

// ==== hw/saturn_core.sv ====
// Core top level joining decoder, register file and ALU behind plain nibble and result ports.
`timescale 1ns/1ps
`default_nettype none

module saturn_core (
    input  wire                  i_clk,
    input  wire                  i_reset,
    // Nibble input.
    input  wire                  i_nib_valid,
    input  wire saturn_pkg::nibble_t i_nibble,
    input  wire saturn_pkg::addr_t   i_nib_addr,
    output logic                 o_nib_ready,
    // Result output.
    output logic                 o_res_valid,
    input  wire                  i_res_ready,
    output saturn_pkg::alu_reg_e o_res_reg,
    output saturn_pkg::word_t    o_res_value,
    output saturn_pkg::addr_t    o_res_pc,
    output logic                 o_res_illegal
);

    saturn_op_if op_bus ();   // Decoder to ALU.
    saturn_rf_if rf_bus ();   // Register file to ALU.

    // ********************************************************************
    // Pipeline: decode, then execute and write back
    // ********************************************************************

    saturn_inst_decoder u_decoder (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_nib_valid (i_nib_valid),
        .i_nibble    (i_nibble),
        .i_nib_addr  (i_nib_addr),
        .o_nib_ready (o_nib_ready),
        .op          (op_bus)
    );

    saturn_reg_file u_reg_file (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .rf      (rf_bus)
    );

    saturn_alu u_alu (
        .i_clk         (i_clk),
        .i_reset       (i_reset),
        .op            (op_bus),
        .rf            (rf_bus),
        .o_res_valid   (o_res_valid),
        .i_res_ready   (i_res_ready),
        .o_res_reg     (o_res_reg),
        .o_res_value   (o_res_value),
        .o_res_pc      (o_res_pc),
        .o_res_illegal (o_res_illegal)
    );

endmodule

`default_nettype wire

// ==== tb/tb_saturn_core.sv ====
// Saturn core testbench with random program, reference model, compare tasks and watchdog.
`timescale 1ns/1ps
`default_nettype none

module tb_saturn_core;
    import saturn_pkg::*;

    localparam int CLK_PERIOD   = 100;             // ns.
    localparam int RESET_CYCLES = 10;
    localparam int N_INSTR      = 400;             // Instructions per run.
    localparam int WATCHDOG_CYC = N_INSTR * 20;    // Cycle budget for the whole run.
    localparam int ADDR_BASE    = 'h01000;         // Address of the first nibble.

    logic     i_clk;
    logic     i_reset;
    logic     i_nib_valid;
    nibble_t  i_nibble;
    addr_t    i_nib_addr;
    logic     o_nib_ready;
    logic     o_res_valid;
    logic     i_res_ready;
    alu_reg_e o_res_reg;
    word_t    o_res_value;
    addr_t    o_res_pc;
    logic     o_res_illegal;

    nibble_t  prog_nib[$];   // Program nibbles in send order.
    alu_reg_e exp_reg[$];    // Expected results in program order.
    word_t    exp_val[$];
    addr_t    exp_pc[$];
    logic     exp_ill[$];
    string    exp_name[$];   // Test name per instruction.

    word_t    model_r[4];    // Reference A to D.
    nibble_t  model_p;       // Reference P.
    int       n_results;     // Results consumed so far.

    saturn_core DUT (
        .i_clk         (i_clk),
        .i_reset       (i_reset),
        .i_nib_valid   (i_nib_valid),
        .i_nibble      (i_nibble),
        .i_nib_addr    (i_nib_addr),
        .o_nib_ready   (o_nib_ready),
        .o_res_valid   (o_res_valid),
        .i_res_ready   (i_res_ready),
        .o_res_reg     (o_res_reg),
        .o_res_value   (o_res_value),
        .o_res_pc      (o_res_pc),
        .o_res_illegal (o_res_illegal)
    );

    initial begin
        i_clk = 1'b0;
        forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
    end

    // ********************************************************************
    // Compare tasks
    // ********************************************************************

    task automatic check_reg(input string name, input alu_reg_e exp, input alu_reg_e act);
        if (exp !== act) begin
            $display("CHECK FAILED %s: expected %s, actual %s", name, exp.name(), act.name());
            $display("test failed");
            $fatal(1, "register mismatch");
        end
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (exp !== act) begin
            $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
            $display("test failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic check_addr(input string name, input addr_t exp, input addr_t act);
        if (exp !== act) begin
            $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
            $display("test failed");
            $fatal(1, "address mismatch");
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
            $display("test failed");
            $fatal(1, "flag mismatch");
        end
    endtask

    // ********************************************************************
    // Reference model
    // ********************************************************************

    function automatic alu_reg_e field_to_reg(input int idx);
        case (idx)
            0:       field_to_reg = ALU_REG_A;
            1:       field_to_reg = ALU_REG_B;
            2:       field_to_reg = ALU_REG_C;
            default: field_to_reg = ALU_REG_D;
        endcase
    endfunction

    function automatic logic opens_block(input nibble_t n);
        opens_block = (n == 4'h2) || (n == 4'h3) || (n >= 4'hC && n <= 4'hE);
    endfunction

    // Legal kinds in equal shares plus one share of illegal first nibbles.
    function automatic nibble_t pick_first();
        case ($urandom_range(5, 0))
            0:       pick_first = 4'h2;
            1:       pick_first = 4'h3;
            2:       pick_first = 4'hC;
            3:       pick_first = 4'hD;
            4:       pick_first = 4'hE;
            default: begin
                pick_first = nibble_t'($urandom_range(15, 0));
                while (opens_block(pick_first)) begin
                    pick_first = nibble_t'($urandom_range(15, 0));
                end
            end
        endcase
    endfunction

    task automatic expect_result(input string name, input alu_reg_e r, input word_t v,
                                 input addr_t pc, input logic ill);
        exp_name.push_back(name);
        exp_reg.push_back(r);
        exp_val.push_back(v);
        exp_pc.push_back(pc);
        exp_ill.push_back(ill);
    endtask

    // Appends one instruction and steps the model in program order.
    task automatic add_instr(input nibble_t n0, input nibble_t n1);
        addr_t pc;
        int    d;
        int    s;
        word_t val;
        string name;
        pc   = addr_t'(ADDR_BASE + prog_nib.size());
        d    = int'(n1[3:2]);
        s    = int'(n1[1:0]);
        name = $sformatf("instr %0d op %h%h", exp_name.size(), n0, n1);
        prog_nib.push_back(n0);
        if (n0 == 4'h2) begin
            prog_nib.push_back(n1);
            model_p = n1;                         // P = n.
            expect_result(name, ALU_REG_P, word_t'(n1), pc, 1'b0);
        end else if (n0 == 4'h3) begin
            prog_nib.push_back(n1);
            val = model_r[2];
            val[4 * int'(model_p[1:0]) +: 4] = n1;  // Nibble P of C.
            model_r[2] = val;
            expect_result(name, ALU_REG_C, val, pc, 1'b0);
        end else if (opens_block(n0)) begin
            prog_nib.push_back(n1);
            if (n0 == 4'hC) begin
                val = model_r[d] + model_r[s];    // Wraps at 16 bits.
            end else if (n0 == 4'hD) begin
                val = model_r[s];
            end else begin
                val = model_r[d] - model_r[s];
            end
            model_r[d] = val;
            expect_result(name, field_to_reg(d), val, pc, 1'b0);
        end else begin
            // One nibble long and no register changes.
            expect_result($sformatf("instr %0d illegal %h", exp_name.size(), n0),
                          ALU_REG_NONE, '0, pc, 1'b1);
        end
    endtask

    // ********************************************************************
    // Result monitor and ready stalls
    // ********************************************************************

    always @(posedge i_clk) begin : result_monitor
        string name;
        if (!i_reset) begin
            if (o_res_valid && i_res_ready) begin
                if (exp_reg.size() == 0) begin
                    $display("DUT gave an extra result at PC %h with no instruction pending",
                             o_res_pc);
                    $display("test failed");
                    $fatal(1, "extra result");
                end else begin
                    name = exp_name.pop_front();
                    check_reg(name, exp_reg.pop_front(), o_res_reg);
                    check_word(name, exp_val.pop_front(), o_res_value);
                    check_addr(name, exp_pc.pop_front(), o_res_pc);
                    check_flag(name, exp_ill.pop_front(), o_res_illegal);
                    n_results <= n_results + 1;
                end
            end
            i_res_ready <= ($urandom_range(3, 0) != 0);  // Stall one cycle in four.
        end
    end

    // ********************************************************************
    // Watchdog
    // ********************************************************************

    initial begin
        repeat (RESET_CYCLES + WATCHDOG_CYC) @(posedge i_clk);
        $display("Watchdog expired: DUT hung with %0d of %0d results seen", n_results, N_INSTR);
        $display("test failed");
        $fatal(1, "timeout");
    end

    // ********************************************************************
    // Main sequence
    // ********************************************************************

    initial begin
        int sent;
        void'($urandom(32'h4c18));
        i_reset     = 1'b1;
        i_nib_valid = 1'b0;
        i_nibble    = '0;
        i_nib_addr  = '0;
        i_res_ready = 1'b0;
        n_results   = 0;
        model_p     = '0;
        for (int i = 0; i < 4; i++) begin
            model_r[i] = '0;
        end
        add_instr(4'hD, 4'h1);                    // A = B shows that B starts clear.
        add_instr(4'h3, 4'h5);                    // C nibble 0 shows that P and C start clear.
        for (int i = 2; i < N_INSTR; i++) begin
            add_instr(pick_first(), nibble_t'($urandom_range(15, 0)));
        end

        repeat (RESET_CYCLES) @(posedge i_clk);
        i_reset <= 1'b0;
        @(posedge i_clk);
        check_flag("reset o_res_valid", 1'b0, o_res_valid);
        check_flag("reset o_nib_ready", 1'b0, o_nib_ready);

        // Each nibble holds until taken and random gaps separate them.
        sent = 0;
        while (sent < prog_nib.size()) begin
            @(posedge i_clk);
            if (i_nib_valid && o_nib_ready) begin
                sent++;
            end
            if (!i_nib_valid || o_nib_ready) begin
                if (sent < prog_nib.size() && $urandom_range(3, 0) != 0) begin
                    i_nib_valid <= 1'b1;
                    i_nibble    <= prog_nib[sent];
                    i_nib_addr  <= addr_t'(ADDR_BASE + sent);
                end else begin
                    i_nib_valid <= 1'b0;
                end
            end
        end

        while (n_results < N_INSTR) begin
            @(posedge i_clk);
        end
        repeat (10) @(posedge i_clk);             // Catch duplicates.
        check_flag("no result after the last instruction", 1'b0, o_res_valid);
        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+include
hw/saturn_pkg.sv
hw/saturn_ifs.sv
hw/saturn_inst_decoder.sv
hw/saturn_reg_file.sv
hw/saturn_alu.sv
hw/saturn_core.sv
tb/tb_saturn_core.sv

// ==== Makefile ====
# Verilator build and run for the Saturn core slice testbench.
TOOL     = verilator
FLAGS    = --binary --timing -j 0 --timescale 1ns/1ps
TOP      = tb_saturn_core
FILELIST = compile.f
OBJ_DIR  = obj_dir
LOG      = sim.log
PASS_MSG = test passed

SOURCES  = $(shell grep -v '^+' $(FILELIST))
HEADERS  = include/saturn_params.svh

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES) $(HEADERS)
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The simulator status is ignored here, the log decides.
run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)
	@echo "Simulation log shows a pass"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
